/* hdl/crypto_config.svh */
`ifndef CRYPTO_CONFIG_SVH
`define CRYPTO_CONFIG_SVH

// key and sponge state width
`define CRYPTO_SECURITY 64

// data word width, one word per sponge block
`define CRYPTO_RATE 16

// byte address step between words
`define CRYPTO_ADDR_STEP 2

// tag length in words
`define CRYPTO_TAG_WORDS (`CRYPTO_SECURITY / 16)

// permutation rounds and round constant
`define CRYPTO_ROUNDS 4
`define CRYPTO_ROUND_CONST 64'h9E37_79B9_7F4A_7C15

`endif

/* hdl/crypto_control.sv */
`timescale 1ns/1ns
`include "crypto_config.svh"

module crypto_control import crypto_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  crypto_op_t                  op,
    input  cmd_regs_t                   regs,
    input  logic [`CRYPTO_SECURITY-1:0] key,
    input  logic [`CRYPTO_RATE-1:0]     mem_rdata,
    output mem_req_t                    mem_req,
    output logic                        busy,
    output logic                        result_valid,
    output logic                        result
);

    sponge_ctrl_t            sponge_ctrl;
    sponge_stat_t            sponge_stat;
    logic                    load_range;
    logic [15:0]             range_base;
    logic [15:0]             range_end;
    logic                    advance;
    logic                    load_out;
    logic [15:0]             out_addr_base;
    logic                    advance_out;
    logic                    select_out;
    logic                    range_done;
    logic [15:0]             mem_addr;
    logic                    mem_en;
    logic                    mem_wr;
    logic [`CRYPTO_RATE-1:0] mem_wdata;

    wrap_sequencer u_seq
    (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .op            (op),
        .regs          (regs),
        .mem_rdata     (mem_rdata),
        .range_done    (range_done),
        .stat          (sponge_stat),
        .ctrl          (sponge_ctrl),
        .load_range    (load_range),
        .range_base    (range_base),
        .range_end     (range_end),
        .advance       (advance),
        .load_out      (load_out),
        .out_addr_base (out_addr_base),
        .advance_out   (advance_out),
        .select_out    (select_out),
        .mem_en        (mem_en),
        .mem_wr        (mem_wr),
        .mem_wdata     (mem_wdata),
        .busy          (busy),
        .result_valid  (result_valid),
        .result        (result)
    );

    mem_addr_unit u_addr
    (
        .clk           (clk),
        .load_range    (load_range),
        .range_base    (range_base),
        .range_end     (range_end),
        .advance       (advance),
        .load_out      (load_out),
        .out_addr_base (out_addr_base),
        .advance_out   (advance_out),
        .select_out    (select_out),
        .range_done    (range_done),
        .addr          (mem_addr)
    );

    sponge_wrap u_sponge
    (
        .clk    (clk),
        .reset  (reset),
        .key    (key),
        .unwrap (op == OP_UNWRAP),
        .ctrl   (sponge_ctrl),
        .stat   (sponge_stat)
    );

    assign mem_req.en    = mem_en;
    assign mem_req.wr    = mem_wr;
    assign mem_req.addr  = mem_addr;
    assign mem_req.wdata = mem_wdata;

endmodule

/* hdl/crypto_pkg.sv */
`include "crypto_config.svh"

package crypto_pkg;

    typedef enum logic
    {
        OP_WRAP   = 1'b0,
        OP_UNWRAP = 1'b1
    } crypto_op_t;

    // byte addresses, ends exclusive
    typedef struct packed
    {
        logic [15:0] ad_base;
        logic [15:0] ad_end;
        logic [15:0] body_base;
        logic [15:0] body_end;
        logic [15:0] out_base;
        logic [15:0] tag_base;
    } cmd_regs_t;

    typedef struct packed
    {
        logic                    en;
        logic                    wr;
        logic [15:0]             addr;
        logic [`CRYPTO_RATE-1:0] wdata;
    } mem_req_t;

    typedef enum logic [1:0]
    {
        MODE_ABSORB  = 2'd0,
        MODE_DUPLEX  = 2'd1,
        MODE_SQUEEZE = 2'd2
    } sponge_mode_t;

    typedef struct packed
    {
        logic                    init;
        logic                    step;
        sponge_mode_t            mode;
        logic                    last;
        logic [`CRYPTO_RATE-1:0] data;
    } sponge_ctrl_t;

    typedef struct packed
    {
        logic                    busy;
        logic                    out_valid;
        logic [`CRYPTO_RATE-1:0] out;
    } sponge_stat_t;

    typedef enum logic [4:0]
    {
        ST_IDLE,
        ST_INIT,
        ST_AD_READ,
        ST_AD_STEP,
        ST_AD_WAIT,
        ST_BODY_LOAD,
        ST_BODY_READ,
        ST_BODY_STEP,
        ST_BODY_WAIT,
        ST_TAG_LOAD,
        ST_TAG_STEP,
        ST_TAG_WAIT,
        ST_DONE
    } seq_state_t;

endpackage

/* hdl/mem_addr_unit.sv */
`timescale 1ns/1ns
`include "crypto_config.svh"

module mem_addr_unit
(
    input  logic        clk,
    input  logic        load_range,
    input  logic [15:0] range_base,
    input  logic [15:0] range_end,
    input  logic        advance,
    input  logic        load_out,
    input  logic [15:0] out_addr_base,
    input  logic        advance_out,
    input  logic        select_out,
    output logic        range_done,
    output logic [15:0] addr
);

    localparam logic [15:0] STEP = 16'(`CRYPTO_ADDR_STEP);

    logic [15:0] range_cnt;
    logic [15:0] range_lim;
    logic [15:0] out_cnt;

    // read pointer over the current range
    always_ff @(posedge clk)
    begin
        if (load_range)
        begin
            range_cnt <= range_base;
            range_lim <= range_end;
        end
        else if (advance)
        begin
            range_cnt <= range_cnt + STEP;
        end
    end

    // write pointer for the body output
    always_ff @(posedge clk)
    begin
        if (load_out)
            out_cnt <= out_addr_base;
        else if (advance_out)
            out_cnt <= out_cnt + STEP;
    end

    assign range_done = range_cnt >= range_lim;

    assign addr = select_out ? out_cnt : range_cnt;

endmodule

/* hdl/sponge_wrap.sv */
`timescale 1ns/1ns
`include "crypto_config.svh"

module sponge_wrap import crypto_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`CRYPTO_SECURITY-1:0] key,
    input  logic                        unwrap,
    input  sponge_ctrl_t                ctrl,
    output sponge_stat_t                stat
);

    localparam int SEC     = `CRYPTO_SECURITY;
    localparam int RATE    = `CRYPTO_RATE;
    localparam int HALF    = SEC / 2;
    localparam int ROUND_W = $clog2(`CRYPTO_ROUNDS + 1);

    logic [SEC-1:0]     state;
    logic [ROUND_W-1:0] round_cnt;
    logic               out_valid;
    logic [RATE-1:0]    out_word;
    logic               accept;
    logic [RATE-1:0]    low_word;
    logic [RATE-1:0]    mixed;
    logic [SEC-1:0]     next_block;

    // add constant, rotate left 13, fold high half into low half
    function automatic logic [SEC-1:0] permute_round(input logic [SEC-1:0] s);
        logic [SEC-1:0] t;
        logic [SEC-1:0] r;
        t = s + `CRYPTO_ROUND_CONST;
        r = (t << 13) | (t >> (SEC - 13));
        return {r[SEC-1:HALF], r[HALF-1:0] ^ r[SEC-1:HALF]};
    endfunction

    assign accept   = ctrl.step && (round_cnt == '0);
    assign low_word = state[RATE-1:0];
    assign mixed    = ctrl.data ^ low_word;

    // block injected before the permutation
    always_comb
    begin
        next_block = state;
        case (ctrl.mode)
            MODE_ABSORB:
                next_block[RATE-1:0] = mixed;
            MODE_DUPLEX:
                next_block[RATE-1:0] = unwrap ? ctrl.data : mixed;
            default:
                next_block[RATE-1:0] = low_word;
        endcase
        if (ctrl.last)
            next_block[SEC-1] = ~next_block[SEC-1];
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.init)
            state <= key;
        else if (accept)
            state <= next_block;
        else if (round_cnt != '0)
            state <= permute_round(state);
    end

    always_ff @(posedge clk)
    begin
        if (reset || ctrl.init)
            round_cnt <= '0;
        else if (accept)
            round_cnt <= ROUND_W'(`CRYPTO_ROUNDS);
        else if (round_cnt != '0)
            round_cnt <= round_cnt - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= accept && (ctrl.mode != MODE_ABSORB);
    end

    // squeeze reads the rate before the permutation
    always_ff @(posedge clk)
    begin
        if (accept)
            out_word <= (ctrl.mode == MODE_SQUEEZE) ? low_word : mixed;
    end

    assign stat.busy      = round_cnt != '0;
    assign stat.out_valid = out_valid;
    assign stat.out       = out_word;

endmodule

/* hdl/wrap_sequencer.sv */
`timescale 1ns/1ns
`include "crypto_config.svh"

module wrap_sequencer import crypto_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  crypto_op_t              op,
    input  cmd_regs_t               regs,
    input  logic [`CRYPTO_RATE-1:0] mem_rdata,
    input  logic                    range_done,
    input  sponge_stat_t            stat,
    output sponge_ctrl_t            ctrl,
    output logic                    load_range,
    output logic [15:0]             range_base,
    output logic [15:0]             range_end,
    output logic                    advance,
    output logic                    load_out,
    output logic [15:0]             out_addr_base,
    output logic                    advance_out,
    output logic                    select_out,
    output logic                    mem_en,
    output logic                    mem_wr,
    output logic [`CRYPTO_RATE-1:0] mem_wdata,
    output logic                    busy,
    output logic                    result_valid,
    output logic                    result
);

    localparam int          TAG_W     = $clog2(`CRYPTO_TAG_WORDS + 1);

    seq_state_t       state;
    seq_state_t       next_state;
    crypto_op_t       op_q;
    cmd_regs_t        regs_q;
    logic             mismatch;
    logic [TAG_W-1:0] tag_cnt;
    logic             tag_last;

    assign tag_last = tag_cnt == TAG_W'(`CRYPTO_TAG_WORDS);

    always_comb
    begin
        case (state)
            ST_IDLE:      next_state = start ? ST_INIT : ST_IDLE;
            ST_INIT:      next_state = ST_AD_READ;
            ST_AD_READ:   next_state = ST_AD_STEP;
            ST_AD_STEP:   next_state = ST_AD_WAIT;
            ST_AD_WAIT:   next_state = stat.busy  ? ST_AD_WAIT   :
                                       range_done ? ST_BODY_LOAD : ST_AD_READ;
            ST_BODY_LOAD: next_state = ST_BODY_READ;
            ST_BODY_READ: next_state = ST_BODY_STEP;
            ST_BODY_STEP: next_state = ST_BODY_WAIT;
            ST_BODY_WAIT: next_state = stat.busy  ? ST_BODY_WAIT :
                                       range_done ? ST_TAG_LOAD  : ST_BODY_READ;
            ST_TAG_LOAD:  next_state = ST_TAG_STEP;
            ST_TAG_STEP:  next_state = ST_TAG_WAIT;
            ST_TAG_WAIT:  next_state = stat.busy  ? ST_TAG_WAIT  :
                                       tag_last   ? ST_DONE      : ST_TAG_STEP;
            default:      next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    // command operands held for the whole run
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && start)
        begin
            op_q   <= op;
            regs_q <= regs;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || state == ST_INIT)
            mismatch <= 1'b0;
        else if (state == ST_TAG_WAIT && stat.out_valid && op_q == OP_UNWRAP
                 && stat.out != mem_rdata)
            mismatch <= 1'b1;
    end

    // squeezed tag words
    always_ff @(posedge clk)
    begin
        if (reset || state == ST_TAG_LOAD)
            tag_cnt <= '0;
        else if (state == ST_TAG_WAIT && stat.out_valid)
            tag_cnt <= tag_cnt + 1'b1;
    end

    always_comb
    begin
        ctrl          = '0;
        load_range    = 1'b0;
        range_base    = regs_q.ad_base;
        range_end     = regs_q.ad_end;
        advance       = 1'b0;
        load_out      = 1'b0;
        out_addr_base = regs_q.out_base;
        advance_out   = 1'b0;
        select_out    = 1'b0;
        mem_en        = 1'b0;
        mem_wr        = 1'b0;
        mem_wdata     = stat.out;
        busy          = state != ST_IDLE;
        result_valid  = 1'b0;
        result        = 1'b0;

        case (state)
            ST_INIT:
            begin
                ctrl.init  = 1'b1;
                load_range = 1'b1;
            end
            ST_AD_READ, ST_BODY_READ:
            begin
                mem_en  = 1'b1;
                advance = 1'b1;
            end
            ST_AD_STEP:
            begin
                ctrl.step = 1'b1;
                ctrl.mode = MODE_ABSORB;
                ctrl.last = range_done;
                ctrl.data = mem_rdata;
            end
            ST_BODY_LOAD:
            begin
                load_range = 1'b1;
                range_base = regs_q.body_base;
                range_end  = regs_q.body_end;
                load_out   = 1'b1;
            end
            ST_BODY_STEP:
            begin
                ctrl.step = 1'b1;
                ctrl.mode = MODE_DUPLEX;
                ctrl.last = range_done;
                ctrl.data = mem_rdata;
            end
            ST_BODY_WAIT:
            begin
                mem_en      = stat.out_valid;
                mem_wr      = stat.out_valid;
                select_out  = stat.out_valid;
                advance_out = stat.out_valid;
            end
            ST_TAG_LOAD:
            begin
                load_range = 1'b1;
                range_base = regs_q.tag_base;
            end
            ST_TAG_STEP:
            begin
                ctrl.step = 1'b1;
                ctrl.mode = MODE_SQUEEZE;
                // unwrap fetches the stored tag word alongside
                mem_en    = op_q == OP_UNWRAP;
            end
            ST_TAG_WAIT:
            begin
                mem_en  = stat.out_valid && op_q == OP_WRAP;
                mem_wr  = stat.out_valid && op_q == OP_WRAP;
                advance = stat.out_valid;
            end
            ST_DONE:
            begin
                result_valid = 1'b1;
                result       = ~mismatch;
            end
            default:
            begin
            end
        endcase
    end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ns --top-module crypto_control_tb \
    -f sources.f -o crypto_sim &&
./obj_dir/crypto_sim | tee /dev/stderr | grep -q "^PASS: all tests$" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* sources.f */
+incdir+hdl
+incdir+verification
hdl/crypto_pkg.sv
hdl/mem_addr_unit.sv
hdl/sponge_wrap.sv
hdl/wrap_sequencer.sv
hdl/crypto_control.sv
verification/crypto_control_tb.sv

/* verification/crypto_model.svh */
`ifndef CRYPTO_MODEL_SVH
`define CRYPTO_MODEL_SVH

// reference rounds of the keyed sponge
function automatic logic [63:0] permute_rounds(input logic [63:0] s);
    logic [63:0] t;
    logic [63:0] r;
    logic [63:0] x;
    x = s;
    for (int i = 0; i < `CRYPTO_ROUNDS; i++)
    begin
        t = x + `CRYPTO_ROUND_CONST;
        r = {t[50:0], t[63:51]};
        x = {r[63:32], r[31:0] ^ r[63:32]};
    end
    return x;
endfunction

function automatic logic [63:0] absorb_block(input logic [63:0] s, input logic [15:0] w,
                                             input logic last);
    logic [63:0] x;
    x = s;
    x[15:0] = x[15:0] ^ w;
    x[63] = x[63] ^ last;
    return permute_rounds(x);
endfunction

// the rate takes the ciphertext word in both directions
function automatic logic [63:0] duplex_block(input logic [63:0] s, input logic [15:0] w,
                                             input logic last, input logic unwrap,
                                             output logic [15:0] out);
    logic [63:0] x;
    x = s;
    out = w ^ x[15:0];
    x[15:0] = unwrap ? w : out;
    x[63] = x[63] ^ last;
    return permute_rounds(x);
endfunction

function automatic logic [63:0] squeeze_block(input logic [63:0] s, output logic [15:0] out);
    out = s[15:0];
    return permute_rounds(s);
endfunction

// word index of a byte address in the 256-word memory
function automatic int mem_index(input logic [15:0] addr);
    return int'(addr[8:1]);
endfunction

function automatic logic [15:0] word_addr(input logic [15:0] base, input int k);
    return base + 16'(k * `CRYPTO_ADDR_STEP);
endfunction

// fill for words outside the command ranges
function automatic logic [15:0] background_word(input int idx);
    return 16'(idx * 40503) ^ 16'h5AC3;
endfunction

`endif

/* verification/crypto_control_tb.sv */
`timescale 1ns/1ns
`include "crypto_config.svh"

module crypto_control_tb import crypto_pkg::*; ();

    localparam int NUM_TESTS       = 8;
    localparam int TAG_WORDS       = `CRYPTO_TAG_WORDS;
    localparam int MAX_WORDS       = 8;
    localparam int MEM_WORDS       = 256;
    localparam int CMD_CYCLES      = 400;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * CMD_CYCLES;

    localparam logic [15:0] AD_BASE   = 16'h0020;
    localparam logic [15:0] BODY_BASE = 16'h0080;
    localparam logic [15:0] OUT_BASE  = 16'h0100;
    localparam logic [15:0] TAG_BASE  = 16'h0180;

    typedef struct packed
    {
        crypto_op_t op;
        int         ad_words;
        int         body_words;
        logic       ad_tweak;
        logic       tag_corrupt;
        logic       exp_result;
    } test_entry_t;

    // unwrap entries take the stimulus and DUT output of the last wrap
    localparam test_entry_t TESTS [NUM_TESTS] = '{
        '{OP_WRAP,   1, 1, 1'b0, 1'b0, 1'b1},
        '{OP_UNWRAP, 1, 1, 1'b0, 1'b0, 1'b1},
        '{OP_WRAP,   6, 8, 1'b0, 1'b0, 1'b1},
        '{OP_UNWRAP, 6, 8, 1'b0, 1'b0, 1'b1},
        '{OP_UNWRAP, 6, 8, 1'b0, 1'b1, 1'b0},
        '{OP_WRAP,   6, 8, 1'b1, 1'b0, 1'b1},
        '{OP_WRAP,   3, 5, 1'b0, 1'b0, 1'b1},
        '{OP_UNWRAP, 3, 5, 1'b0, 1'b0, 1'b1}
    };

    logic                        clk;
    logic                        reset;
    logic                        start;
    crypto_op_t                  op;
    cmd_regs_t                   regs;
    logic [`CRYPTO_SECURITY-1:0] key;
    logic [`CRYPTO_RATE-1:0]     mem_rdata;
    mem_req_t                    mem_req;
    logic                        busy;
    logic                        result_valid;
    logic                        result;

    int          seed;
    int          value_errs;
    int          other_errs;
    int          write_count;
    logic [15:0] read_word;
    logic [15:0] mem [MEM_WORDS];
    logic [15:0] ad_buf [MAX_WORDS];
    logic [15:0] pt_buf [MAX_WORDS];
    logic [15:0] body_in [MAX_WORDS];
    logic [15:0] exp_out [MAX_WORDS];
    logic [15:0] exp_tag [TAG_WORDS];
    logic [15:0] saved_ct [MAX_WORDS];
    logic [15:0] saved_tag [TAG_WORDS];

    `include "crypto_model.svh"

    crypto_control dut
    (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .op           (op),
        .regs         (regs),
        .key          (key),
        .mem_rdata    (mem_rdata),
        .mem_req      (mem_req),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired after %0d cycles, a command never finished",
                 WATCHDOG_CYCLES);
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        $display("FAIL: see errors above");
        $finish;
    end

    // word memory, reads answer one cycle later
    always @(posedge clk)
    begin
        if (mem_req.en === 1'b1)
        begin
            assert (mem_req.addr < 16'(MEM_WORDS * 2))
            else
            begin
                $display("memory access outside the model at address %h", mem_req.addr);
                other_errs++;
            end
            if (mem_req.wr)
            begin
                mem[mem_index(mem_req.addr)] = mem_req.wdata;
                write_count++;
            end
            else
            begin
                read_word = mem[mem_index(mem_req.addr)];
                #1;
                mem_rdata = read_word;
            end
        end
    end

    function automatic string test_name(input int t);
        case (t)
            0:       return "wrap_single";
            1:       return "unwrap_single";
            2:       return "wrap_long";
            3:       return "unwrap_long";
            4:       return "unwrap_bad_tag";
            5:       return "wrap_ad_changed";
            6:       return "wrap_mid";
            7:       return "unwrap_mid";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_word(input string name, input string what, input int idx,
                              input logic [15:0] expected, input logic [15:0] actual);
        assert (actual === expected)
        else
        begin
            $display("Fail %s: %s[%0d] expected %h actual %h", name, what, idx, expected, actual);
            value_errs++;
        end
    endtask

    task automatic check_idle(input string name);
        assert (busy === 1'b0 && result_valid === 1'b0 && mem_req.en === 1'b0)
        else
        begin
            $display("%s: controller not idle before start (busy %b, result_valid %b, en %b)",
                     name, busy, result_valid, mem_req.en);
            other_errs++;
        end
    endtask

    task automatic build_image(input test_entry_t e);
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = background_word(i);
        for (int k = 0; k < e.ad_words; k++)
            mem[mem_index(word_addr(AD_BASE, k))] = ad_buf[k];
        for (int k = 0; k < e.body_words; k++)
        begin
            body_in[k] = (e.op == OP_WRAP) ? pt_buf[k] : saved_ct[k];
            mem[mem_index(word_addr(BODY_BASE, k))] = body_in[k];
        end
        if (e.op == OP_UNWRAP)
        begin
            for (int k = 0; k < TAG_WORDS; k++)
                mem[mem_index(word_addr(TAG_BASE, k))] =
                    saved_tag[k] ^ ((e.tag_corrupt && k == 1) ? 16'h8000 : 16'h0000);
        end
    endtask

    task automatic compute_expected(input test_entry_t e);
        logic [63:0] s;
        s = key;
        for (int k = 0; k < e.ad_words; k++)
            s = absorb_block(s, ad_buf[k], k == e.ad_words - 1);
        for (int k = 0; k < e.body_words; k++)
            s = duplex_block(s, body_in[k], k == e.body_words - 1, e.op == OP_UNWRAP,
                             exp_out[k]);
        for (int k = 0; k < TAG_WORDS; k++)
            s = squeeze_block(s, exp_tag[k]);
    endtask

    task automatic run_command(input string name, output logic got_valid,
                               output logic got_result);
        int cycles;
        got_valid  = 1'b0;
        got_result = 1'b0;
        cycles     = 0;
        @(posedge clk);
        #1;
        start = 1'b1;
        @(negedge clk);
        assert (busy === 1'b0)
        else
        begin
            $display("%s: busy rose in the same cycle as start", name);
            other_errs++;
        end
        @(posedge clk);
        #1;
        start = 1'b0;
        while (!got_valid && cycles < CMD_CYCLES)
        begin
            @(negedge clk);
            assert (busy === 1'b1)
            else
            begin
                $display("%s: busy low at cycle %0d of the command", name, cycles);
                other_errs++;
            end
            if (result_valid === 1'b1)
            begin
                got_valid  = 1'b1;
                got_result = result;
            end
            @(posedge clk);
            #1;
            // stray start while busy, its operands must not be taken
            start         = (cycles == 3);
            regs.out_base = start ? OUT_BASE + 16'h0040 : OUT_BASE;
            regs.tag_base = start ? TAG_BASE + 16'h0040 : TAG_BASE;
            cycles++;
        end
        start = 1'b0;
        if (!got_valid)
        begin
            $display("%s: no result_valid within %0d cycles", name, CMD_CYCLES);
            other_errs++;
        end
        repeat (2)
        begin
            @(negedge clk);
            assert (busy === 1'b0 && result_valid === 1'b0)
            else
            begin
                $display("%s: busy or result_valid still high after the result pulse", name);
                other_errs++;
            end
        end
    endtask

    initial
    begin
        test_entry_t e;
        string       name;
        logic        got_valid;
        logic        got_result;
        logic        tag_changed;
        int          exp_writes;
        seed         = 32'h243b_e9cc;
        value_errs   = 0;
        other_errs   = 0;
        write_count  = 0;
        reset        = 1'b1;
        start        = 1'b0;
        op           = OP_WRAP;
        regs         = '0;
        mem_rdata    = '0;
        key          = {32'($random(seed)), 32'($random(seed))};
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            e    = TESTS[t];
            name = test_name(t);
            if (e.op == OP_WRAP && !e.ad_tweak)
            begin
                for (int k = 0; k < MAX_WORDS; k++)
                begin
                    ad_buf[k] = 16'($random(seed));
                    pt_buf[k] = 16'($random(seed));
                end
            end
            // one AD word differs from the previous wrap
            if (e.ad_tweak)
                ad_buf[0] = ad_buf[0] ^ 16'h0400;
            build_image(e);
            compute_expected(e);

            @(posedge clk);
            #1;
            op             = e.op;
            regs.ad_base   = AD_BASE;
            regs.ad_end    = word_addr(AD_BASE, e.ad_words);
            regs.body_base = BODY_BASE;
            regs.body_end  = word_addr(BODY_BASE, e.body_words);
            regs.out_base  = OUT_BASE;
            regs.tag_base  = TAG_BASE;
            write_count    = 0;
            @(negedge clk);
            check_idle(name);
            run_command(name, got_valid, got_result);

            assert (got_result === e.exp_result)
            else
            begin
                $display("Fail %s: result expected %0d actual %0d", name, e.exp_result,
                         got_result);
                value_errs++;
            end
            exp_writes = e.body_words + ((e.op == OP_WRAP) ? TAG_WORDS : 0);
            assert (write_count == exp_writes)
            else
            begin
                $display("Fail %s: write count expected %0d actual %0d", name, exp_writes,
                         write_count);
                value_errs++;
            end

            if (e.op == OP_WRAP)
            begin
                tag_changed = 1'b0;
                for (int k = 0; k < e.body_words; k++)
                    check_word(name, "ciphertext", k, exp_out[k],
                               mem[mem_index(word_addr(OUT_BASE, k))]);
                for (int k = 0; k < TAG_WORDS; k++)
                begin
                    check_word(name, "tag", k, exp_tag[k],
                               mem[mem_index(word_addr(TAG_BASE, k))]);
                    if (mem[mem_index(word_addr(TAG_BASE, k))] !== saved_tag[k])
                        tag_changed = 1'b1;
                end
                if (e.ad_tweak)
                begin
                    assert (tag_changed)
                    else
                    begin
                        $display("%s: tag did not change when one AD word changed", name);
                        other_errs++;
                    end
                end
                for (int k = 0; k < e.body_words; k++)
                    saved_ct[k] = mem[mem_index(word_addr(OUT_BASE, k))];
                for (int k = 0; k < TAG_WORDS; k++)
                    saved_tag[k] = mem[mem_index(word_addr(TAG_BASE, k))];
            end
            else
            begin
                for (int k = 0; k < e.body_words; k++)
                    check_word(name, "plaintext", k, pt_buf[k],
                               mem[mem_index(word_addr(OUT_BASE, k))]);
            end
        end

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule
